// ==== hw/controlPkg.sv ====
`default_nettype none

package controlPkg;

    typedef enum logic [5:0] {
        fetchPc, fetchWait1, fetchWait2, decode,
        aritCalc, aritStore, breakOrNop, jumpRegister, branch,
        memAddress, memAddressWait1, memAddressWait2,
        memRead, memReadWait1, memReadWait2, memReadStore, memWrite,
        aritImmCalc, aritImmStore, loadImm, jump,
        excpEpcWrite, excpRead, excpWait1, excpWait2, excpTreat
    } controlState;

    typedef enum logic [3:0] {
        clsArit, clsShift, clsSlt, clsNop, clsBreak, clsJr, clsJump, clsJal,
        clsLoad, clsStore, clsLui, clsBranchEq, clsBranchNe, clsArithImm, clsSltImm, clsIllegal
    } instructionClass;

    typedef enum logic [2:0] {
        aluLoad, aluAdd, aluSub, aluAnd, aluInc, aluNeg, aluXor, aluCompare
    } aluOpcode;

    typedef enum logic [2:0] {
        shiftNop, shiftLoad, shiftLeft, shiftRightLogic, shiftRightArith,
        shiftRotateRight, shiftRotateLeft
    } shiftOpcode;

    // primary opcodes
    localparam logic [5:0] opRType = 6'h00, opJ = 6'h02, opJal = 6'h03, opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05, opAddi = 6'h08, opAddiu = 6'h09, opSlti = 6'h0a;
    localparam logic [5:0] opAndi = 6'h0c, opXori = 6'h0e, opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23, opSw = 6'h2b;

    // funct field of R-type
    localparam logic [5:0] fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnSllv = 6'h04;
    localparam logic [5:0] fnSrav = 6'h07, fnJr = 6'h08, fnBreak = 6'h0d;
    localparam logic [5:0] fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22, fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24, fnXor = 6'h26, fnSlt = 6'h2a;

    localparam int selWidth = 4;
    localparam int regDstWidth = 3;

    localparam logic [selWidth-1:0] pcSourceAlu = 4'd0, pcSourceBranch = 4'd1;
    localparam logic [selWidth-1:0] pcSourceJump = 4'd2, pcSourceTrap = 4'd3;

    localparam logic [selWidth-1:0] iOrDPc = 4'd0, iOrDAlu = 4'd1;
    localparam logic [selWidth-1:0] iOrDTrapVector = 4'd2;  // fixed handler slot

    localparam logic [selWidth-1:0] aluSrcAPc = 4'd0, aluSrcARegA = 4'd1;

    localparam logic [selWidth-1:0] aluSrcBRegB = 4'd0, aluSrcBFour = 4'd1;
    localparam logic [selWidth-1:0] aluSrcBImm = 4'd2, aluSrcBBranch = 4'd3;  // imm << 2

    localparam logic [selWidth-1:0] memToRegAlu = 4'd0, memToRegMdr = 4'd1;
    localparam logic [selWidth-1:0] memToRegUpperImm = 4'd2, memToRegShift = 4'd3;
    localparam logic [selWidth-1:0] memToRegPc = 4'd4, memToRegSet = 4'd5;
    localparam logic [selWidth-1:0] memToRegClear = 4'd6;

    localparam logic [regDstWidth-1:0] regDstRt = 3'd0, regDstRd = 3'd1, regDstRa = 3'd2;

    localparam logic causeIllegal = 1'b0;
    localparam logic causeOverflow = 1'b1;

endpackage

`default_nettype wire

// ==== hw/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder import controlPkg::*; (
    input  wire logic [5:0] opcode,
    input  wire logic [5:0] funct,
    input  wire logic [4:0] shamt,
    output instructionClass instrClass
);

    always_comb begin
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnXor:
                        instrClass = clsArit;
                    fnSlt:
                        instrClass = clsSlt;
                    fnSll: begin
                        if (shamt == 5'd0)
                            instrClass = clsNop;  // sll $0,$0,0 is the canonical nop
                        else
                            instrClass = clsShift;
                    end
                    fnSllv, fnSra, fnSrav, fnSrl:
                        instrClass = clsShift;
                    fnJr:
                        instrClass = clsJr;
                    fnBreak:
                        instrClass = clsBreak;
                    default:
                        instrClass = clsNop;  // unknown funct just refetches
                endcase
            end
            opJ:     instrClass = clsJump;
            opJal:   instrClass = clsJal;
            opBeq:   instrClass = clsBranchEq;
            opBne:   instrClass = clsBranchNe;
            opAddi, opAddiu, opAndi, opXori:
                instrClass = clsArithImm;
            opSlti:  instrClass = clsSltImm;
            opLui:   instrClass = clsLui;
            opLw:    instrClass = clsLoad;
            opSw:    instrClass = clsStore;
            default: instrClass = clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer import controlPkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,
    input  instructionClass instrClass,
    input  wire logic [5:0] opcode,
    input  wire logic [5:0] funct,
    input  wire logic       overflow,
    output controlState     state,
    output logic            causeWrite,
    output logic            intCause
);

    controlState nextState;
    logic aritTrap;
    logic immTrap;

    // only the signed forms trap, addu/subu/addiu wrap silently
    assign aritTrap = overflow && instrClass == clsArit && (funct == fnAdd || funct == fnSub);
    assign immTrap = overflow && opcode == opAddi;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= fetchPc;
        else
            state <= nextState;
    end

    always_comb begin
        causeWrite = 1'b0;
        intCause = causeIllegal;
        case (state)
            fetchPc:    nextState = fetchWait1;
            fetchWait1: nextState = fetchWait2;
            fetchWait2: nextState = decode;
            decode: begin
                case (instrClass)
                    clsArit, clsShift, clsSlt: nextState = aritCalc;
                    clsNop, clsBreak:          nextState = breakOrNop;
                    clsJr:                     nextState = jumpRegister;
                    clsJump, clsJal:           nextState = jump;
                    clsLoad, clsStore:         nextState = memAddress;
                    clsLui:                    nextState = loadImm;
                    clsBranchEq, clsBranchNe:  nextState = branch;
                    clsArithImm, clsSltImm:    nextState = aritImmCalc;
                    default: begin
                        causeWrite = 1'b1;  // undefined opcode
                        nextState = excpEpcWrite;
                    end
                endcase
            end
            aritCalc: begin
                if (aritTrap) begin
                    causeWrite = 1'b1;
                    intCause = causeOverflow;
                    nextState = excpEpcWrite;
                end else begin
                    nextState = aritStore;
                end
            end
            aritImmCalc: begin
                if (immTrap) begin
                    causeWrite = 1'b1;
                    intCause = causeOverflow;
                    nextState = excpEpcWrite;
                end else begin
                    nextState = aritImmStore;
                end
            end
            breakOrNop: nextState = (instrClass == clsBreak) ? breakOrNop : fetchPc;  // break hangs
            memAddress:      nextState = memAddressWait1;
            memAddressWait1: nextState = memAddressWait2;
            memAddressWait2: nextState = (instrClass == clsStore) ? memWrite : memRead;
            memRead:         nextState = memReadWait1;
            memReadWait1:    nextState = memReadWait2;
            memReadWait2:    nextState = memReadStore;
            excpEpcWrite:    nextState = excpRead;
            excpRead:        nextState = excpWait1;
            excpWait1:       nextState = excpWait2;
            excpWait2:       nextState = excpTreat;
            default:         nextState = fetchPc;  // single-cycle executes and excpTreat
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/aluControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluControl import controlPkg::*; (
    input  controlState     state,
    input  instructionClass instrClass,
    input  wire logic [5:0] funct,
    input  wire logic [5:0] opcode,
    output aluOpcode        aluOp,
    output shiftOpcode      shiftOp,
    output logic            shiftAmountSource
);

    always_comb begin
        aluOp = aluLoad;
        shiftOp = shiftNop;
        shiftAmountSource = 1'b0;
        case (state)
            fetchWait1, fetchWait2, decode: aluOp = aluAdd;  // pc + 4, then branch target
            aritCalc: begin
                if (instrClass == clsShift) begin
                    shiftAmountSource = (funct == fnSllv || funct == fnSrav);  // register amount
                    case (funct)
                        fnSll, fnSllv: shiftOp = shiftLeft;
                        fnSra, fnSrav: shiftOp = shiftRightArith;
                        fnSrl:         shiftOp = shiftRightLogic;
                        default:       shiftOp = shiftNop;
                    endcase
                end else begin
                    case (funct)
                        fnAdd, fnAddu: aluOp = aluAdd;
                        fnSub, fnSubu: aluOp = aluSub;
                        fnAnd:         aluOp = aluAnd;
                        fnXor:         aluOp = aluXor;
                        fnSlt:         aluOp = aluCompare;
                        default:       aluOp = aluLoad;
                    endcase
                end
            end
            aritImmCalc: begin
                case (opcode)
                    opAddi, opAddiu: aluOp = aluAdd;
                    opAndi:          aluOp = aluAnd;
                    opSlti:          aluOp = aluCompare;
                    opXori:          aluOp = aluXor;
                    default:         aluOp = aluLoad;
                endcase
            end
            aritStore, aritImmStore: aluOp = aluCompare;  // keep less stable for the write
            branch, excpEpcWrite: aluOp = aluSub;  // compare a-b / pc - 4 for epc
            memAddress, memAddressWait1, memAddressWait2, memRead, memReadWait1,
            memReadWait2, memReadStore, memWrite:
                aluOp = aluAdd;
            default: aluOp = aluLoad;
        endcase
        if (state == decode)
            shiftOp = shiftLoad;
    end

endmodule

`default_nettype wire

// ==== hw/datapathControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathControl import controlPkg::*; (
    input  controlState                   state,
    input  instructionClass               instrClass,
    input  wire logic                     zero,
    input  wire logic                     less,
    input  wire logic                     cause,
    output logic                          pcWrite,
    output logic                          memWrite,
    output logic                          irWrite,
    output logic                          regWrite,
    output logic                          aWrite,
    output logic                          bWrite,
    output logic                          aluOutWrite,
    output logic                          mdrWrite,
    output logic                          epcWrite,
    output logic                          treatSrc,
    output logic [selWidth-1:0]           iOrD,
    output logic [selWidth-1:0]           pcSource,
    output logic [selWidth-1:0]           aluSrcA,
    output logic [selWidth-1:0]           aluSrcB,
    output logic [selWidth-1:0]           memToReg,
    output logic [regDstWidth-1:0]        regDst
);

    logic branchTaken;
    logic [selWidth-1:0] setOrClear;

    assign branchTaken = (instrClass == clsBranchEq) ? zero : !zero;
    assign setOrClear = less ? memToRegSet : memToRegClear;

    always_comb begin
        pcWrite = 1'b0;
        memWrite = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        aWrite = 1'b0;
        bWrite = 1'b0;
        aluOutWrite = 1'b0;
        mdrWrite = 1'b0;
        epcWrite = 1'b0;
        treatSrc = 1'b0;
        iOrD = iOrDPc;
        pcSource = pcSourceAlu;
        aluSrcA = aluSrcARegA;
        aluSrcB = aluSrcBRegB;
        memToReg = memToRegAlu;
        regDst = regDstRt;
        case (state)
            fetchPc, fetchWait1, fetchWait2: begin
                mdrWrite = 1'b1;
                aluSrcA = aluSrcAPc;
                aluSrcB = aluSrcBFour;
                pcWrite = (state == fetchWait2);  // ir and pc latch on the last wait
                irWrite = (state == fetchWait2);
            end
            decode: begin
                aWrite = 1'b1;
                bWrite = 1'b1;
                aluOutWrite = 1'b1;  // branch target, in case it is one
                aluSrcA = aluSrcAPc;
                aluSrcB = aluSrcBBranch;
            end
            aritCalc: aluOutWrite = 1'b1;
            aritStore: begin
                regWrite = 1'b1;
                regDst = regDstRd;
                if (instrClass == clsSlt)
                    memToReg = setOrClear;
                else if (instrClass == clsShift)
                    memToReg = memToRegShift;
            end
            jumpRegister: pcWrite = 1'b1;  // alu passes a through
            branch: begin
                pcWrite = branchTaken;
                pcSource = pcSourceBranch;
            end
            memAddress, memAddressWait1, memAddressWait2, aritImmCalc: begin
                aluOutWrite = 1'b1;
                aluSrcB = aluSrcBImm;
            end
            memRead, memReadWait1, memReadWait2, memReadStore: begin
                mdrWrite = 1'b1;
                iOrD = iOrDAlu;
                regWrite = (state == memReadStore);
                memToReg = memToRegMdr;
            end
            controlPkg::memWrite: begin  // the state, not the strobe
                memWrite = 1'b1;
                iOrD = iOrDAlu;
            end
            aritImmStore: begin
                regWrite = 1'b1;
                aluSrcB = aluSrcBImm;
                if (instrClass == clsSltImm)
                    memToReg = setOrClear;
            end
            loadImm: begin
                regWrite = 1'b1;
                memToReg = memToRegUpperImm;
            end
            jump: begin
                pcWrite = 1'b1;
                pcSource = pcSourceJump;
                if (instrClass == clsJal) begin
                    regWrite = 1'b1;  // link into $ra
                    memToReg = memToRegPc;
                    regDst = regDstRa;
                end
            end
            excpEpcWrite: begin
                epcWrite = 1'b1;
                aluSrcA = aluSrcAPc;
                aluSrcB = aluSrcBFour;
            end
            excpRead, excpWait1, excpWait2: iOrD = iOrDTrapVector;
            excpTreat: begin
                pcWrite = 1'b1;
                pcSource = pcSourceTrap;
                treatSrc = cause;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import controlPkg::*; (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic [5:0]               opcode,
    input  wire logic [5:0]               funct,
    input  wire logic [4:0]               shamt,
    input  wire logic                     zero,
    input  wire logic                     overflow,
    input  wire logic                     less,
    input  wire logic                     cause,
    output logic                          pcWrite,
    output logic                          memWrite,
    output logic                          irWrite,
    output logic                          regWrite,
    output logic                          aWrite,
    output logic                          bWrite,
    output logic                          aluOutWrite,
    output logic                          mdrWrite,
    output logic                          epcWrite,
    output logic                          causeWrite,
    output logic                          treatSrc,
    output logic                          intCause,
    output logic [selWidth-1:0]           iOrD,
    output logic [selWidth-1:0]           pcSource,
    output logic [selWidth-1:0]           aluSrcA,
    output logic [selWidth-1:0]           aluSrcB,
    output logic [selWidth-1:0]           memToReg,
    output logic [regDstWidth-1:0]        regDst,
    output aluOpcode                      aluOp,
    output shiftOpcode                    shiftOp,
    output logic                          shiftAmountSource,
    output logic [5:0]                    stateOut
);

    instructionClass instrClass;
    controlState state;

    assign stateOut = state;  // raw encoding for debug

    instructionDecoder decoderInst (
        .opcode(opcode), .funct(funct), .shamt(shamt), .instrClass(instrClass)
    );

    stateSequencer sequencerInst (
        .clock(clock), .reset(reset), .instrClass(instrClass), .opcode(opcode),
        .funct(funct), .overflow(overflow), .state(state), .causeWrite(causeWrite),
        .intCause(intCause)
    );

    aluControl aluControlInst (
        .state(state), .instrClass(instrClass), .funct(funct), .opcode(opcode),
        .aluOp(aluOp), .shiftOp(shiftOp), .shiftAmountSource(shiftAmountSource)
    );

    datapathControl datapathInst (
        .state(state), .instrClass(instrClass), .zero(zero), .less(less), .cause(cause),
        .pcWrite(pcWrite), .memWrite(memWrite), .irWrite(irWrite), .regWrite(regWrite),
        .aWrite(aWrite), .bWrite(bWrite), .aluOutWrite(aluOutWrite), .mdrWrite(mdrWrite),
        .epcWrite(epcWrite), .treatSrc(treatSrc), .iOrD(iOrD), .pcSource(pcSource),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .memToReg(memToReg), .regDst(regDst)
    );

endmodule

`default_nettype wire

// ==== verification/controlUnit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitProps import controlPkg::*; (
    input  wire logic  clock,
    input  wire logic  reset,
    input  controlState state,
    input  wire logic  causeWrite
);

    resetToFetch: assert property (@(posedge clock) reset |=> state == fetchPc)
        else $error("state did not go to fetchPc under reset");

    // every trap enters through the epc write
    trapEntry: assert property (@(posedge clock) disable iff (reset)
        causeWrite |=> state == excpEpcWrite)
        else $error("causeWrite was not followed by excpEpcWrite");

    fetchToDecode: assert property (@(posedge clock) disable iff (reset)
        state == fetchWait2 |=> state == decode)
        else $error("fetchWait2 was not followed by decode");

endmodule

bind stateSequencer controlUnitProps props (
    .clock(clock),
    .reset(reset),
    .state(state),
    .causeWrite(causeWrite)
);

`default_nettype wire

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb import controlPkg::*; ();

    localparam int fieldsPerTest = 14;
    localparam int maxTests = 64;
    localparam int breakCycles = 20;

    logic clock;
    logic reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    logic zero;
    logic overflow;
    logic less;
    logic cause;
    logic pcWrite;
    logic memWrite;
    logic irWrite;
    logic regWrite;
    logic aWrite;
    logic bWrite;
    logic aluOutWrite;
    logic mdrWrite;
    logic epcWrite;
    logic causeWrite;
    logic treatSrc;
    logic intCause;
    logic [selWidth-1:0] iOrD;
    logic [selWidth-1:0] pcSource;
    logic [selWidth-1:0] aluSrcA;
    logic [selWidth-1:0] aluSrcB;
    logic [selWidth-1:0] memToReg;
    logic [regDstWidth-1:0] regDst;
    aluOpcode aluOp;
    shiftOpcode shiftOp;
    logic shiftAmountSource;
    logic [5:0] stateOut;

    logic [7:0] testMem [0:fieldsPerTest*maxTests-1];
    int numTests = 0;
    int currentTest = 0;
    int errorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    controlUnit dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic showMismatch(input string name, input int actual, input int expected);
        errorCount++;
        $display("[ERROR] %0t ns test %0d %s: got %0d, expected %0d",
                 $time, currentTest, name, actual, expected);
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("[ERROR] %0t ns %s", $time, what);
    endtask

    function automatic shiftOpcode shiftOfFunct(input logic [5:0] fn);
        case (fn)
            fnSll, fnSllv: return shiftLeft;
            fnSra, fnSrav: return shiftRightArith;
            fnSrl:         return shiftRightLogic;
            default:       return shiftNop;
        endcase
    endfunction

    // rd for R-type, $ra for jal, rt otherwise
    function automatic logic [regDstWidth-1:0] destinationOf(input logic [5:0] op);
        if (op == opRType)
            return regDstRd;
        else if (op == opJal)
            return regDstRa;
        else
            return regDstRt;
    endfunction

    function automatic logic [selWidth-1:0] pcSourceIn(input controlState st);
        case (st)
            branch:    return pcSourceBranch;
            jump:      return pcSourceJump;
            excpTreat: return pcSourceTrap;
            default:   return pcSourceAlu;  // pc + 4 and jr through the alu
        endcase
    endfunction

    // selects and strobes that follow from the state and the fields
    task automatic checkOutputs();
        controlState st;
        logic isShift;
        logic regAmount;
        shiftOpcode expShift;
        logic [selWidth-1:0] expSrcB;
        st = controlState'(stateOut);
        isShift = opcode == opRType && (funct == fnSllv || funct == fnSrav ||
                  funct == fnSra || funct == fnSrl || (funct == fnSll && shamt != 5'd0));
        regAmount = isShift && st == aritCalc && (funct == fnSllv || funct == fnSrav);
        if (st == decode)
            expShift = shiftLoad;
        else if (isShift && st == aritCalc)
            expShift = shiftOfFunct(funct);
        else
            expShift = shiftNop;
        if (shiftOp != expShift)
            showMismatch("shiftOp", int'(shiftOp), int'(expShift));
        if (shiftAmountSource != regAmount)
            showMismatch("shiftAmountSource", int'(shiftAmountSource), int'(regAmount));
        if (irWrite != (st == fetchWait2))
            showMismatch("irWrite", int'(irWrite), int'(st == fetchWait2));
        if (epcWrite != (st == excpEpcWrite))
            showMismatch("epcWrite", int'(epcWrite), int'(st == excpEpcWrite));
        if (treatSrc != ((st == excpTreat) && cause))
            showMismatch("treatSrc", int'(treatSrc), int'((st == excpTreat) && cause));
        if (st == fetchPc || st == fetchWait1 || st == fetchWait2) begin
            if (iOrD != iOrDPc)
                showMismatch("iOrD", int'(iOrD), int'(iOrDPc));
            if (aluSrcA != aluSrcAPc)
                showMismatch("aluSrcA", int'(aluSrcA), int'(aluSrcAPc));
            if (aluSrcB != aluSrcBFour)
                showMismatch("aluSrcB", int'(aluSrcB), int'(aluSrcBFour));
            if (pcWrite != (st == fetchWait2))
                showMismatch("pcWrite", int'(pcWrite), int'(st == fetchWait2));
        end
        if (st == decode) begin
            if (aluOp != aluAdd)
                showMismatch("aluOp in decode", int'(aluOp), int'(aluAdd));
            if (!aWrite || !bWrite)
                reportProblem("registers A and B were not loaded in decode");
        end
        if (st == aritCalc || st == aritImmCalc || st == memAddress) begin
            expSrcB = (st == aritCalc) ? aluSrcBRegB : aluSrcBImm;
            if (aluSrcA != aluSrcARegA)
                showMismatch("aluSrcA", int'(aluSrcA), int'(aluSrcARegA));
            if (aluSrcB != expSrcB)
                showMismatch("aluSrcB", int'(aluSrcB), int'(expSrcB));
            if (!aluOutWrite)
                reportProblem("the ALU result was not latched in the execute cycle");
        end
        if ((memWrite || st == memRead) && iOrD != iOrDAlu)
            showMismatch("iOrD", int'(iOrD), int'(iOrDAlu));
        if (st == memReadWait2 && !mdrWrite)
            reportProblem("mdrWrite was low on the last memory read wait");
        if (pcWrite && pcSource != pcSourceIn(st))
            showMismatch("pcSource", int'(pcSource), int'(pcSourceIn(st)));
        if (regWrite && regDst != destinationOf(opcode))
            showMismatch("regDst", int'(regDst), int'(destinationOf(opcode)));
    endtask

    // one instruction, from fetchPc until fetchPc comes back
    task automatic runTest(input int idx);
        int base;
        int cycles;
        int regWrites;
        int pcWrites;
        int causeWrites;
        int memWrites;
        int excpCycles;
        int expCycles;
        int expMemWrites;
        logic [selWidth-1:0] writtenSel;
        logic sampledCause;
        logic seenDecode;
        logic done;
        base = idx * fieldsPerTest;
        opcode = testMem[base][5:0];
        funct = testMem[base+1][5:0];
        shamt = testMem[base+2][4:0];
        zero = testMem[base+3][0];
        overflow = testMem[base+4][0];
        less = testMem[base+5][0];
        cause = testMem[base+6][0];
        expCycles = int'(testMem[base+7]);
        expMemWrites = (opcode == opSw) ? 1 : 0;
        cycles = 0;
        regWrites = 0;
        pcWrites = 0;
        causeWrites = 0;
        memWrites = 0;
        excpCycles = 0;
        writtenSel = '0;
        sampledCause = 1'b0;
        seenDecode = 1'b0;
        done = 1'b0;
        if (stateOut != fetchPc)
            reportProblem($sformatf("test %0d did not start in fetchPc", idx));
        while (!done) begin
            @(negedge clock);
            checkOutputs();
            if (seenDecode) begin
                cycles++;
                if (cycles == 1 && aluOp != aluOpcode'(testMem[base+8][2:0]))
                    showMismatch("aluOp", int'(aluOp), int'(testMem[base+8]));
                if (pcWrite) pcWrites++;
            end
            if (stateOut == decode) seenDecode = 1'b1;
            if (stateOut >= excpEpcWrite && stateOut <= excpTreat) excpCycles++;
            if (memWrite) memWrites++;
            if (regWrite) begin
                regWrites++;
                writtenSel = memToReg;
            end
            if (causeWrite) begin
                causeWrites++;
                sampledCause = intCause;
            end
            @(posedge clock);
            #1;
            if (stateOut == fetchPc) done = 1'b1;
            if (expCycles == 0 && cycles == breakCycles) done = 1'b1;  // break never returns
        end
        if (expCycles == 0) begin
            if (stateOut != breakOrNop)
                showMismatch("stateOut", int'(stateOut), int'(breakOrNop));
        end else if (cycles != expCycles) begin
            showMismatch("cycles after decode", cycles, expCycles);
        end
        if (regWrites != int'(testMem[base+9]))
            showMismatch("regWrite count", regWrites, int'(testMem[base+9]));
        if (regWrites > 0 && writtenSel != testMem[base+10][3:0])
            showMismatch("memToReg", int'(writtenSel), int'(testMem[base+10]));
        if (pcWrites != int'(testMem[base+11]))
            showMismatch("pcWrite count", pcWrites, int'(testMem[base+11]));
        if (causeWrites != int'(testMem[base+12]))
            showMismatch("causeWrite count", causeWrites, int'(testMem[base+12]));
        if (causeWrites > 0 && sampledCause != testMem[base+13][0])
            showMismatch("intCause", int'(sampledCause), int'(testMem[base+13]));
        if (excpCycles != ((causeWrites > 0) ? 5 : 0))
            showMismatch("exception cycles", excpCycles, (causeWrites > 0) ? 5 : 0);
        if (memWrites != expMemWrites)
            showMismatch("memWrite count", memWrites, expMemWrites);
    endtask

    initial begin
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        shamt = '0;
        zero = 1'b0;
        overflow = 1'b0;
        less = 1'b0;
        cause = 1'b0;
        $readmemh("verification/controlUnit_tests.txt", testMem);
        // the break line closes the list
        while (numTests < maxTests && testMem[numTests*fieldsPerTest+7] != 8'd0)
            numTests++;
        if (numTests == maxTests)
            reportProblem("the test file has no closing break line");
        else
            numTests++;
        for (int i = 0; i < numTests; i++)
            cycleLimit += int'(testMem[i*fieldsPerTest+7]) + 8;
        cycleLimit += 50;

        @(negedge clock);
        if (stateOut != fetchPc)
            showMismatch("stateOut in reset", int'(stateOut), int'(fetchPc));
        if ({pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite, epcWrite,
             causeWrite, memWrite} != 9'd0)
            showMismatch("enables in reset", int'({pcWrite, irWrite, regWrite, aWrite,
                         bWrite, aluOutWrite, epcWrite, causeWrite, memWrite}), 0);
        @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < numTests; i++) begin
            currentTest = i;
            runTest(i);
        end

        $display("tests run: %0d, errors: %0d", numTests, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/controlUnit_tests.txt ====
// opcode funct shamt zero overflow less cause | cycles aluOp regWrites memToReg pcWrites causeWrites intCause
// cycles are counted after decode; 00 on the last line marks break, which must hang
00 20 00 0 0 0 0  02 1 1 0 0 0 0  // add
00 20 00 0 1 0 1  06 1 0 0 1 1 1  // add, overflow traps
00 21 00 0 1 0 0  02 1 1 0 0 0 0  // addu, overflow ignored
00 22 00 0 1 0 1  06 2 0 0 1 1 1  // sub, overflow traps
00 23 00 0 1 0 0  02 2 1 0 0 0 0  // subu, overflow ignored
00 24 00 0 0 0 0  02 3 1 0 0 0 0  // and
00 26 00 0 0 0 0  02 6 1 0 0 0 0  // xor
00 2a 00 0 0 1 0  02 7 1 5 0 0 0  // slt, less set
00 2a 00 0 0 0 0  02 7 1 6 0 0 0  // slt, less clear
00 00 04 0 0 0 0  02 0 1 3 0 0 0  // sll by 4
00 04 00 0 0 0 0  02 0 1 3 0 0 0  // sllv
00 03 02 0 0 0 0  02 0 1 3 0 0 0  // sra
00 07 00 0 0 0 0  02 0 1 3 0 0 0  // srav
00 02 01 0 0 0 0  02 0 1 3 0 0 0  // srl
00 00 00 0 0 0 0  01 0 0 0 0 0 0  // nop
00 08 00 0 0 0 0  01 0 0 0 1 0 0  // jr
02 00 00 0 0 0 0  01 0 0 0 1 0 0  // j
03 00 00 0 0 0 0  01 0 1 4 1 0 0  // jal
0f 00 00 0 0 0 0  01 0 1 2 0 0 0  // lui
04 00 00 1 0 0 0  01 2 0 0 1 0 0  // beq taken
04 00 00 0 0 0 0  01 2 0 0 0 0 0  // beq not taken
05 00 00 0 0 0 0  01 2 0 0 1 0 0  // bne taken
05 00 00 1 0 0 0  01 2 0 0 0 0 0  // bne not taken
08 00 00 0 0 0 0  02 1 1 0 0 0 0  // addi
08 00 00 0 1 0 1  06 1 0 0 1 1 1  // addi, overflow traps
09 00 00 0 1 0 0  02 1 1 0 0 0 0  // addiu, overflow ignored
0c 00 00 0 0 0 0  02 3 1 0 0 0 0  // andi
0a 00 00 0 0 1 0  02 7 1 5 0 0 0  // slti, less set
0a 00 00 0 0 0 0  02 7 1 6 0 0 0  // slti, less clear
0e 00 00 0 0 0 0  02 6 1 0 0 0 0  // xori
23 00 00 0 0 0 0  07 1 1 1 0 0 0  // lw
2b 00 00 0 0 0 0  04 1 0 0 0 0 0  // sw
3f 00 00 0 0 0 0  05 2 0 0 1 1 0  // undefined opcode
00 0d 00 0 0 0 0  00 0 0 0 0 0 0  // break

// ==== all.f ====
hw/controlPkg.sv
hw/instructionDecoder.sv
hw/stateSequencer.sv
hw/aluControl.sv
hw/datapathControl.sv
hw/controlUnit.sv
verification/controlUnit_props.sv
verification/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module controlUnitTb \
    -f all.f -o controlUnitSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/controlUnitSim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
